// ==== logic/csi2_pkg.sv ====
package csi2_pkg;

  // ******************************
  // RAW10 group geometry
  // ******************************
  localparam int BYTE_W         = 8;
  localparam int BYTES_PER_WORD = 5;                         // Four MSB bytes, one LSB byte
  localparam int PX_PER_WORD    = 4;
  localparam int PX_W           = 10;
  localparam int OUT_W          = 16;                        // Output pixel beat width

  localparam int LANE_W   = $clog2(BYTES_PER_WORD);
  localparam int PX_IDX_W = $clog2(PX_PER_WORD);

  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(BYTES_PER_WORD - 1);

  // Byte 0 is the first byte received and sits in bits 7:0
  typedef logic [BYTES_PER_WORD-1:0][BYTE_W-1:0] raw10_word_t;

  typedef struct packed
  {
    logic [OUT_W-PX_W-1:0] pad;                              // Always zero
    logic [PX_W-1:0]       value;
  } pixel_t;

endpackage

// ==== logic/stream_pkg.sv ====
package stream_pkg;

  // ******************************
  // Stream beats
  // ******************************
  typedef struct packed
  {
    logic [csi2_pkg::BYTE_W-1:0] data;
    logic                        last;
  } byte_beat_t;

  typedef struct packed
  {
    csi2_pkg::raw10_word_t data;
    logic                  last;                             // Closing word of the line
  } word_beat_t;

  typedef struct packed
  {
    csi2_pkg::pixel_t data;
    logic             last;                                  // Line end
    logic             user;                                  // Frame start
  } px_beat_t;

endpackage

// ==== logic/stream_reg_slice.sv ====
`timescale 1ns/1ps

module stream_reg_slice
#(
  parameter type payload_t = logic
)
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

logic     skid_valid;
payload_t skid_data;
logic     out_free;

// Ready comes from a register, so the ready path is cut here
assign in_ready_o = !skid_valid;
assign out_free   = out_ready_i || !out_valid_o;             // Main reg can load

// ******************************
// Control
// ******************************
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      out_valid_o <= 1'b0;
      skid_valid  <= 1'b0;
    end
  else
    begin
      if( out_free )
        begin
          out_valid_o <= skid_valid || in_valid_i;
          skid_valid  <= 1'b0;                               // Skid drains first
        end
      else
        begin
          if( in_valid_i && in_ready_o )
            skid_valid <= 1'b1;                              // Output stalled, park beat
        end
    end

// ******************************
// Payload
// ******************************
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    out_data_o <= '0;
  else if( out_free && ( skid_valid || in_valid_i ) )
    out_data_o <= skid_valid ? skid_data : in_data_i;

always_ff @( posedge clk_i )
  if( !out_free && in_valid_i && in_ready_o )
    skid_data <= in_data_i;

endmodule

// ==== logic/csi2_byte_packer.sv ====
`timescale 1ns/1ps

module csi2_byte_packer
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   byte_valid_i,
  input  stream_pkg::byte_beat_t byte_i,
  output logic                   byte_ready_o,
  output logic                   word_valid_o,
  output stream_pkg::word_beat_t word_o,
  input  logic                   word_ready_i
);

logic [csi2_pkg::LANE_W-1:0] byte_cnt;
csi2_pkg::raw10_word_t       word_data;
logic                        word_last;
logic                        byte_xfer;
logic                        word_done;

// Stall only while a finished word is stuck downstream
assign byte_ready_o = !word_valid_o || word_ready_i;
assign byte_xfer    = byte_valid_i && byte_ready_o;
assign word_done    = byte_xfer && ( byte_cnt == csi2_pkg::LAST_LANE );

// ******************************
// Lane counter and word control
// ******************************
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      byte_cnt     <= '0;
      word_valid_o <= 1'b0;
      word_last    <= 1'b0;
    end
  else
    begin
      if( byte_xfer )
        begin
          if( word_done )
            byte_cnt <= '0;
          else
            byte_cnt <= byte_cnt + 1'b1;
        end

      if( word_done )
        begin
          word_valid_o <= 1'b1;
          word_last    <= byte_i.last;                       // Last only sits in lane 4
        end
      else
        begin
          if( word_ready_i )
            word_valid_o <= 1'b0;
        end
    end

// Each byte lands in its own lane of the word
always_ff @( posedge clk_i )
  if( byte_xfer )
    word_data[byte_cnt] <= byte_i.data;

assign word_o = '{ data: word_data, last: word_last };

endmodule

// ==== logic/csi2_px_serializer.sv ====
`timescale 1ns/1ps

module csi2_px_serializer
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   frame_start_i,
  input  logic                   word_valid_i,
  input  stream_pkg::word_beat_t word_i,
  output logic                   word_ready_o,
  output logic                   px_valid_o,
  output stream_pkg::px_beat_t   px_o,
  input  logic                   px_ready_i
);

typedef enum logic [csi2_pkg::PX_IDX_W-1:0]
{
  PX_0,
  PX_1,
  PX_2,
  PX_3
} px_state_t;

px_state_t             state;
px_state_t             next_state;
csi2_pkg::raw10_word_t word_reg;
csi2_pkg::raw10_word_t word_src;
csi2_pkg::pixel_t      px_data;
logic                  px_last;
logic                  px_user;
logic                  start_flag;
logic                  last_word;
logic                  word_xfer;
logic                  px_xfer;

// Pixel k is byte k over bit pair k of the LSB byte
function automatic csi2_pkg::pixel_t pick_px( input csi2_pkg::raw10_word_t w,
                                              input logic [csi2_pkg::PX_IDX_W-1:0] k );
  csi2_pkg::pixel_t p;
  p.pad   = '0;
  p.value = { w[k], w[csi2_pkg::BYTES_PER_WORD-1][2*k +: 2] };
  return p;
endfunction

assign word_ready_o = ( state == PX_0 ) && px_ready_i;
assign word_xfer    = word_valid_i && word_ready_o;
assign px_xfer      = px_valid_o && px_ready_i;
assign word_src     = ( state == PX_0 ) ? word_i.data : word_reg; // Pixel 0 straight from input

// ******************************
// FSM
// ******************************
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    state <= PX_0;
  else
    state <= next_state;

always_comb
  begin
    next_state = state;
    case( state )
      PX_0: if( word_xfer )  next_state = PX_1;
      PX_1: if( px_ready_i ) next_state = PX_2;
      PX_2: if( px_ready_i ) next_state = PX_3;
      PX_3: if( px_ready_i ) next_state = PX_0;
      default: next_state = PX_0;
    endcase
  end

always_ff @( posedge clk_i )
  if( word_xfer )
    word_reg <= word_i.data;

// ******************************
// Frame start and line end flags
// ******************************
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      start_flag <= 1'b0;
      last_word  <= 1'b0;
    end
  else
    begin
      if( frame_start_i )
        start_flag <= 1'b1;
      else if( px_xfer && px_user )
        start_flag <= 1'b0;                                  // Marked pixel has left
      if( word_xfer )
        last_word <= word_i.last;
    end

// Output beat, held while px_ready_i is low
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      px_valid_o <= 1'b0;
      px_data    <= '0;
      px_last    <= 1'b0;
      px_user    <= 1'b0;
    end
  else
    begin
      if( px_ready_i && ( state != PX_0 || word_xfer ) )
        begin
          px_valid_o <= 1'b1;
          px_data    <= pick_px( word_src, state );
          px_last    <= ( state == PX_3 ) && last_word;
          px_user    <= ( state == PX_0 ) && start_flag;
        end
      else if( px_ready_i )
        begin
          px_valid_o <= 1'b0;                                // No word waiting
          px_last    <= 1'b0;
          px_user    <= 1'b0;
        end
    end

assign px_o = '{ data: px_data, last: px_last, user: px_user };

endmodule

// ==== logic/csi2_raw10_rx.sv ====
`timescale 1ns/1ps

module csi2_raw10_rx
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   frame_start_i,
  input  logic                   byte_valid_i,
  input  stream_pkg::byte_beat_t byte_i,
  output logic                   byte_ready_o,
  output logic                   px_valid_o,
  output stream_pkg::px_beat_t   px_o,
  input  logic                   px_ready_i
);

// ******************************
// Internal stream links
// ******************************
logic                   in_valid;
stream_pkg::byte_beat_t in_beat;
logic                   in_ready;

logic                   word_valid;
stream_pkg::word_beat_t word_beat;
logic                   word_ready;

logic                   ser_valid;
stream_pkg::px_beat_t   ser_beat;
logic                   ser_ready;

stream_reg_slice #(
  .payload_t   ( stream_pkg::byte_beat_t )
) u_in_slice (
  .clk_i       ( clk_i        ),
  .rst_i       ( rst_i        ),
  .in_valid_i  ( byte_valid_i ),
  .in_data_i   ( byte_i       ),
  .in_ready_o  ( byte_ready_o ),
  .out_valid_o ( in_valid     ),
  .out_data_o  ( in_beat      ),
  .out_ready_i ( in_ready     )
);

csi2_byte_packer u_packer (
  .clk_i        ( clk_i      ),
  .rst_i        ( rst_i      ),
  .byte_valid_i ( in_valid   ),
  .byte_i       ( in_beat    ),
  .byte_ready_o ( in_ready   ),
  .word_valid_o ( word_valid ),
  .word_o       ( word_beat  ),
  .word_ready_i ( word_ready )
);

csi2_px_serializer u_serializer (
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .frame_start_i ( frame_start_i ),
  .word_valid_i  ( word_valid    ),
  .word_i        ( word_beat     ),
  .word_ready_o  ( word_ready    ),
  .px_valid_o    ( ser_valid     ),
  .px_o          ( ser_beat      ),
  .px_ready_i    ( ser_ready     )
);

stream_reg_slice #(
  .payload_t   ( stream_pkg::px_beat_t )
) u_out_slice (
  .clk_i       ( clk_i      ),
  .rst_i       ( rst_i      ),
  .in_valid_i  ( ser_valid  ),
  .in_data_i   ( ser_beat   ),
  .in_ready_o  ( ser_ready  ),
  .out_valid_o ( px_valid_o ),
  .out_data_o  ( px_o       ),
  .out_ready_i ( px_ready_i )
);

endmodule

// ==== testbench/csi2_raw10_rx_chk.sv ====
`timescale 1ns/1ps

module csi2_raw10_rx_chk
(
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 in_ready_i,
  input logic                 out_valid_i,
  input stream_pkg::px_beat_t out_beat_i,
  input logic                 out_ready_i,
  input logic                 ser_valid_i,
  input stream_pkg::px_beat_t ser_beat_i
);

int fail_count = 0;

// ******************************
// Stream protocol
// ******************************
a_out_hold: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  out_valid_i && !out_ready_i |=> out_valid_i && $stable( out_beat_i ) )
  else
    begin
      fail_count++;
      $error( "Output beat changed while px_ready_i was low" );
    end

// Flags leave the serializer only with a valid beat
a_flags_valid: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  ( ser_beat_i.user || ser_beat_i.last ) |-> ser_valid_i )
  else
    begin
      fail_count++;
      $error( "User or last set without valid" );
    end

a_ctrl_known: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  !$isunknown( { out_valid_i, in_ready_i } ) )
  else
    begin
      fail_count++;
      $error( "Unknown valid or ready after reset" );
    end

a_beat_known: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  !$isunknown( out_beat_i ) )
  else
    begin
      fail_count++;
      $error( "Unknown output beat after reset" );
    end

endmodule

bind csi2_raw10_rx csi2_raw10_rx_chk u_chk
(
  .clk_i       ( clk_i        ),
  .rst_i       ( rst_i        ),
  .in_ready_i  ( byte_ready_o ),
  .out_valid_i ( px_valid_o   ),
  .out_beat_i  ( px_o         ),
  .out_ready_i ( px_ready_i   ),
  .ser_valid_i ( ser_valid    ),
  .ser_beat_i  ( ser_beat     )
);

// ==== testbench/csi2_raw10_rx_tb.sv ====
`timescale 1ns/1ps

module csi2_raw10_rx_tb;

localparam int PERIOD      = 8;
localparam int RST_CYCLES  = 8;
localparam int BP_WORDS    = 40;
localparam int TOTAL_BYTES = 5 + 20 + 20 + 5*BP_WORDS;       // Bytes over all tests
localparam int WAIT_LIMIT  = 500;

logic                   clk_i         = 1'b0;
logic                   rst_i         = 1'b1;
logic                   frame_start_i = 1'b0;
logic                   byte_valid_i  = 1'b0;
stream_pkg::byte_beat_t byte_i        = '0;
logic                   px_ready_i    = 1'b1;
logic                   byte_ready_o;
logic                   px_valid_o;
stream_pkg::px_beat_t   px_o;

integer                 seed          = 32'h9d901236;
int                     errors        = 0;
int                     tests         = 0;
logic                   bp_en         = 1'b0;
logic                   start_pending = 1'b0;
stream_pkg::byte_beat_t tx_q[$];
logic [17:0]            exp_q[$];                            // Pad, pixel, last, user
logic [17:0]            got_q[$];

always #( PERIOD/2 ) clk_i = ~clk_i;

csi2_raw10_rx dut_i
(
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .frame_start_i ( frame_start_i ),
  .byte_valid_i  ( byte_valid_i  ),
  .byte_i        ( byte_i        ),
  .byte_ready_o  ( byte_ready_o  ),
  .px_valid_o    ( px_valid_o    ),
  .px_o          ( px_o          ),
  .px_ready_i    ( px_ready_i    )
);

// ******************************
// Monitor and output ready
// ******************************
always @( posedge clk_i )
  begin
    if( px_valid_o && px_ready_i )
      got_q.push_back( px_o );
    px_ready_i <= bp_en ? 1'($random( seed )) : 1'b1;
  end

function automatic logic [39:0] random_word();
  return { $random( seed ), 8'($random( seed )) };
endfunction

// Five bytes in, four pixels of byte k over bit pair k of byte 4 out
task automatic add_word( input logic [39:0] w, input logic last );
  stream_pkg::byte_beat_t beat;
  logic [9:0]             value;
  for( int k = 0; k < 5; k++ )
    begin
      beat.data = w[8*k +: 8];
      beat.last = last && ( k == 4 );
      tx_q.push_back( beat );
    end
  for( int k = 0; k < 4; k++ )
    begin
      value = { w[8*k +: 8], w[32 + 2*k +: 2] };
      exp_q.push_back( { 6'b0, value, last && ( k == 3 ), start_pending && ( k == 0 ) } );
    end
  start_pending = 1'b0;
endtask

task automatic pulse_frame_start();
  frame_start_i <= 1'b1;
  @( posedge clk_i );
  frame_start_i <= 1'b0;
  start_pending = 1'b1;
endtask

task automatic send_bytes();
  while( tx_q.size() > 0 )
    begin
      byte_valid_i <= 1'b1;
      byte_i       <= tx_q.pop_front();
      do
        @( posedge clk_i );
      while( !byte_ready_o );
    end
  byte_valid_i <= 1'b0;
endtask

task automatic finish_test( input string name, input int bad );
  tests++;
  errors += bad;
  $display( "Test %-15s %s", name, ( bad == 0 ) ? "passed" : "failed" );
endtask

task automatic check_pixels( input string name );
  int cycles;
  int bad;
  cycles = 0;
  bad    = 0;
  while( got_q.size() < exp_q.size() && cycles < WAIT_LIMIT )
    begin
      @( posedge clk_i );
      cycles++;
    end
  repeat( 10 ) @( posedge clk_i );                           // Room for extra pixels
  assert( cycles < WAIT_LIMIT )
  else
    begin
      $display( "%s: timed out waiting for output pixels", name );
      bad++;
    end
  assert( got_q.size() == exp_q.size() )
  else
    begin
      $display( "[FAIL] %s: pixel count expected %0d actual %0d",
                name, exp_q.size(), got_q.size() );
      bad++;
    end
  for( int i = 0; i < exp_q.size() && i < got_q.size(); i++ )
    assert( got_q[i] == exp_q[i] )
    else
      begin
        $display( "[FAIL] %s: pixel %0d expected %h actual %h", name, i, exp_q[i], got_q[i] );
        bad++;
      end
  finish_test( name, bad );
  exp_q.delete();
  got_q.delete();
endtask

// ******************************
// Directed tests
// ******************************
task automatic reset_test();
  int bad;
  bad = 0;
  for( int c = 0; c < RST_CYCLES + 8; c++ )
    begin
      @( posedge clk_i );
      if( c == RST_CYCLES - 1 )
        rst_i <= 1'b0;
      if( c > 0 )                                            // First edge applies reset
        begin
          assert( px_valid_o == 1'b0 )
          else
            begin
              $display( "[FAIL] reset: px_valid_o expected 0 actual %b", px_valid_o );
              bad++;
            end
        end
    end
  finish_test( "reset", bad );
endtask

task automatic unpack_test();
  add_word( 40'hE4_F0_5A_A5_81, 1'b0 );                     // Distinct bit pair per pixel
  send_bytes();
  check_pixels( "unpack" );
endtask

task automatic frame_start_test();
  pulse_frame_start();
  add_word( random_word(), 1'b0 );
  add_word( random_word(), 1'b1 );
  send_bytes();
  check_pixels( "frame_start" );
  add_word( random_word(), 1'b0 );
  add_word( random_word(), 1'b1 );
  send_bytes();
  check_pixels( "no_frame_start" );
endtask

task automatic line_end_test();
  for( int i = 0; i < 4; i++ )
    add_word( random_word(), i == 3 );
  send_bytes();
  check_pixels( "line_end" );
endtask

task automatic back_pressure_test();
  bp_en = 1'b1;
  for( int i = 0; i < BP_WORDS; i++ )
    add_word( random_word(), ( i % 8 ) == 7 );               // Lines of eight words
  send_bytes();
  check_pixels( "back_pressure" );
  bp_en = 1'b0;
endtask

initial
  begin
    reset_test();
    unpack_test();
    frame_start_test();
    line_end_test();
    back_pressure_test();
    errors += dut_i.u_chk.fail_count;
    $display( "Summary: %0d tests run, %0d errors", tests, errors );
    if( errors == 0 )
      $display( "All tests passed!" );
    else
      $display( "Test failures found" );
    $finish;
  end

initial
  begin
    #( ( TOTAL_BYTES*4 + RST_CYCLES + 600 ) * PERIOD );
    $display( "Watchdog expired before the tests completed" );
    $display( "Test failures found" );
    $finish;
  end

endmodule

// ==== csi2_raw10_rx.f ====
logic/csi2_pkg.sv
logic/stream_pkg.sv
logic/stream_reg_slice.sv
logic/csi2_byte_packer.sv
logic/csi2_px_serializer.sv
logic/csi2_raw10_rx.sv
testbench/csi2_raw10_rx_chk.sv
testbench/csi2_raw10_rx_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module csi2_raw10_rx_tb -f csi2_raw10_rx.f \
  && ./obj_dir/Vcsi2_raw10_rx_tb | tee sim.log
grep -q "All tests passed!" sim.log && exit 0 || exit 1
